// File: Makefile
TOP       ?= tb_core
VERILATOR ?= verilator
FLAGS     ?= --assert
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

// File: src/exec_unit.sv
`timescale 1ns/10ps

module exec_unit import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       inst_valid,
  input  word_t      inst,
  output logic       inst_taken,
  output logic       lsu_start,
  output logic       lsu_store,
  output word_t      lsu_addr,
  output word_t      lsu_wdata,
  output mem_width_e lsu_width,
  input  word_t      lsu_rdata,
  input  logic       lsu_done,
  output logic       halted
);

  typedef enum logic [1:0] {idle, wait_mem, halt} exec_state_e;

  exec_state_e           state;
  decoded_t              dec;
  word_t                 regs [32];
  word_t                 rs1_val;
  word_t                 rs2_val;
  word_t                 alu_b;
  word_t                 alu_out;
  logic                  is_mem;
  logic                  is_ebreak;
  logic                  writes_alu;
  logic [reg_addr_w-1:0] rd_q;
  logic                  load_q;
  logic                  wr_en;
  logic [reg_addr_w-1:0] wr_addr;
  word_t                 wr_data;

  function automatic decoded_t decode(word_t i);
    decoded_t d;
    d.opcode = opcode_e'(i[6:0]);
    d.rd     = i[11:7];
    d.funct3 = i[14:12];
    d.rs1    = i[19:15];
    d.rs2    = i[24:20];
    d.funct7 = i[31:25];
    d.i_imm  = {{20{i[31]}}, i[31:20]};
    d.s_imm  = {{20{i[31]}}, i[31:25], i[11:7]};
    d.u_imm  = {i[31:12], 12'h000};
    d.alu_op = alu_add;
    if (d.opcode == op_reg || d.opcode == op_imm) begin
      case (d.funct3)
        // sub only exists in the reg-reg group
        3'b000:  d.alu_op = (d.opcode == op_reg && d.funct7[5]) ? alu_sub : alu_add;
        3'b001:  d.alu_op = alu_sll;
        3'b010:  d.alu_op = alu_slt;
        3'b011:  d.alu_op = alu_sltu;
        3'b100:  d.alu_op = alu_xor;
        3'b101:  d.alu_op = d.funct7[5] ? alu_sra : alu_srl;
        3'b110:  d.alu_op = alu_or;
        default: d.alu_op = alu_and;
      endcase
    end
    return d;
  endfunction

  // ************************************************************
  // decode and operand read
  // ************************************************************

  assign dec        = decode(inst);
  assign rs1_val    = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_val    = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
  assign is_mem     = dec.opcode == op_load || dec.opcode == op_store;
  assign is_ebreak  = dec.opcode == op_system && dec.funct3 == 3'b000 &&
                      dec.i_imm[11:0] == 12'd1;
  assign writes_alu = dec.opcode == op_reg || dec.opcode == op_imm || dec.opcode == op_lui;

  // one instruction at a time, nothing taken while busy or halted
  assign inst_taken = state == idle && inst_valid;

  assign alu_b = (dec.opcode == op_reg) ? rs2_val : dec.i_imm;

  always_comb begin
    case (dec.alu_op)
      alu_add:  alu_out = rs1_val + alu_b;
      alu_sub:  alu_out = rs1_val - alu_b;
      alu_sll:  alu_out = rs1_val << alu_b[4:0];
      alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(alu_b)};
      alu_sltu: alu_out = {{(xlen-1){1'b0}}, rs1_val < alu_b};
      alu_xor:  alu_out = rs1_val ^ alu_b;
      alu_srl:  alu_out = rs1_val >> alu_b[4:0];
      alu_sra:  alu_out = word_t'($signed(rs1_val) >>> alu_b[4:0]);
      alu_or:   alu_out = rs1_val | alu_b;
      default:  alu_out = rs1_val & alu_b;
    endcase
  end

  // ************************************************************
  // memory ops and write-back
  // ************************************************************

  assign lsu_start = inst_taken && is_mem;
  assign lsu_store = dec.opcode == op_store;
  assign lsu_addr  = rs1_val + (lsu_store ? dec.s_imm : dec.i_imm);
  assign lsu_wdata = rs2_val;
  assign lsu_width = mem_width_e'(dec.funct3);

  always_ff @(posedge clk) begin
    if (lsu_start) begin
      rd_q   <= dec.rd;
      load_q <= !lsu_store;
    end
  end

  always_comb begin
    if (state == wait_mem) begin
      wr_en   = lsu_done && load_q;
      wr_addr = rd_q;
      wr_data = lsu_rdata;
    end else begin
      wr_en   = inst_taken && writes_alu;
      wr_addr = dec.rd;
      wr_data = (dec.opcode == op_lui) ? dec.u_imm : alu_out;
    end
  end

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (inst_taken && is_mem) begin
            state <= wait_mem;
          end else if (inst_taken && is_ebreak) begin
            state <= halt;
          end
        end
        wait_mem: begin
          if (lsu_done) begin
            state <= idle;
          end
        end
        default: state <= halt;
      endcase
    end
  end

  assign halted = state == halt;

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stop,
  output mem_req_t fetch_req,
  input  mem_rsp_t fetch_rsp,
  output logic     inst_valid,
  output word_t    inst,
  output word_t    inst_pc,
  input  logic     inst_taken
);

  word_t pc;
  logic  req_pending;
  logic  buf_valid;
  logic  want_fetch;
  logic  fill;

  // prefetch while the buffer drains
  assign want_fetch = !req_pending && (!buf_valid || inst_taken) && !stop;
  // words arriving after stop are dropped
  assign fill = fetch_rsp.done && !stop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc          <= reset_pc;
      req_pending <= 1'b0;
      buf_valid   <= 1'b0;
    end else begin
      if (fetch_rsp.done) begin
        req_pending <= 1'b0;
      end else if (want_fetch) begin
        req_pending <= 1'b1;
      end
      if (fill) begin
        buf_valid <= 1'b1;
        pc        <= pc + word_t'(4);
      end else if (inst_taken) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      inst    <= fetch_rsp.rdata;
      inst_pc <= pc;
    end
  end

  always_comb begin
    fetch_req.valid = req_pending;
    fetch_req.write = 1'b0;
    fetch_req.addr  = pc;
    fetch_req.wdata = '0;
    fetch_req.strb  = '0;
  end

  assign inst_valid = buf_valid;

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       lsu_start,
  input  logic       lsu_store,
  input  word_t      lsu_addr,
  input  word_t      lsu_wdata,
  input  mem_width_e lsu_width,
  output word_t      lsu_rdata,
  output logic       lsu_done,
  output mem_req_t   data_req,
  input  mem_rsp_t   data_rsp
);

  logic       req_valid;
  logic       store_q;
  word_t      addr_q;
  word_t      wdata_q;
  mem_width_e width_q;
  logic [1:0] ofs;
  logic [4:0] lane_shift;
  word_t      rd_shift;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else if (lsu_start) begin
      req_valid <= 1'b1;
    end else if (data_rsp.done) begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_start) begin
      store_q <= lsu_store;
      addr_q  <= lsu_addr;
      wdata_q <= lsu_wdata;
      width_q <= lsu_width;
    end
  end

  assign ofs        = addr_q[1:0];
  assign lane_shift = {ofs, 3'b000};

  // store side: move data to its byte lane
  always_comb begin
    data_req.valid = req_valid;
    data_req.write = store_q;
    data_req.addr  = {addr_q[xlen-1:2], 2'b00};
    data_req.wdata = wdata_q << lane_shift;
    case (width_q)
      mem_b, mem_bu: data_req.strb = 4'b0001 << ofs;
      mem_h, mem_hu: data_req.strb = 4'b0011 << ofs;
      default:       data_req.strb = 4'b1111;
    endcase
  end

  // load side: bring addressed lane down, then extend
  assign rd_shift = data_rsp.rdata >> lane_shift;

  always_comb begin
    case (width_q)
      mem_b:   lsu_rdata = {{24{rd_shift[7]}}, rd_shift[7:0]};
      mem_bu:  lsu_rdata = {24'h000000, rd_shift[7:0]};
      mem_h:   lsu_rdata = {{16{rd_shift[15]}}, rd_shift[15:0]};
      mem_hu:  lsu_rdata = {16'h0000, rd_shift[15:0]};
      default: lsu_rdata = data_rsp.rdata;
    endcase
  end

  assign lsu_done = data_rsp.done;

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t fetch_req,
  output mem_rsp_t fetch_rsp,
  input  mem_req_t data_req,
  output mem_rsp_t data_rsp,
  output axi_req_t axi_out,
  input  axi_rsp_t axi_in
);

  typedef enum logic [2:0] {idle, rd_addr, rd_data, wr_addr, wr_resp} arb_state_e;

  arb_state_e state;
  logic       grant_data;
  logic       aw_ok;
  logic       w_ok;
  logic       done_q;
  word_t      rdata_q;
  mem_req_t   sel_req;
  logic       aw_hs;
  logic       w_hs;
  logic       last_hs;

  assign sel_req = grant_data ? data_req : fetch_req;

  always_comb begin
    axi_out.awvalid = state == wr_addr && !aw_ok;
    axi_out.awaddr  = sel_req.addr;
    axi_out.wvalid  = state == wr_addr && !w_ok;
    axi_out.wdata   = sel_req.wdata;
    axi_out.wstrb   = sel_req.strb;
    axi_out.bready  = state == wr_resp;
    axi_out.arvalid = state == rd_addr;
    axi_out.araddr  = sel_req.addr;
    axi_out.rready  = state == rd_data;
  end

  assign aw_hs   = axi_out.awvalid && axi_in.awready;
  assign w_hs    = axi_out.wvalid && axi_in.wready;
  assign last_hs = (state == rd_data && axi_in.rvalid) || (state == wr_resp && axi_in.bvalid);

  // ************************************************************
  // grant and channel sequencing
  // ************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= idle;
      grant_data <= 1'b0;
      aw_ok      <= 1'b0;
      w_ok       <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= last_hs;
      case (state)
        idle: begin
          // hold off while done is out, the requester still shows valid
          if (!done_q && (data_req.valid || fetch_req.valid)) begin
            grant_data <= data_req.valid;
            aw_ok      <= 1'b0;
            w_ok       <= 1'b0;
            if (data_req.valid ? data_req.write : fetch_req.write) begin
              state <= wr_addr;
            end else begin
              state <= rd_addr;
            end
          end
        end
        rd_addr: begin
          if (axi_in.arready) begin
            state <= rd_data;
          end
        end
        wr_addr: begin
          if (aw_hs) begin
            aw_ok <= 1'b1;
          end
          if (w_hs) begin
            w_ok <= 1'b1;
          end
          if ((aw_ok || aw_hs) && (w_ok || w_hs)) begin
            state <= wr_resp;
          end
        end
        default: begin
          if (last_hs) begin
            state <= idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rd_data && axi_in.rvalid) begin
      rdata_q <= axi_in.rdata;
    end
  end

  // only the granted side sees the answer
  always_comb begin
    fetch_rsp.done  = done_q && !grant_data;
    fetch_rsp.rdata = grant_data ? '0 : rdata_q;
    data_rsp.done   = done_q && grant_data;
    data_rsp.rdata  = grant_data ? rdata_q : '0;
  end

endmodule

// File: src/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  output axi_req_t axi_out,
  input  axi_rsp_t axi_in,
  output logic     halted
);

  mem_req_t   fetch_req;
  mem_rsp_t   fetch_rsp;
  mem_req_t   data_req;
  mem_rsp_t   data_rsp;
  logic       inst_valid;
  word_t      inst;
  logic       inst_taken;
  logic       lsu_start;
  logic       lsu_store;
  word_t      lsu_addr;
  word_t      lsu_wdata;
  mem_width_e lsu_width;
  word_t      lsu_rdata;
  logic       lsu_done;

  // instruction pc is not needed without branches
  fetch_unit #(
    .reset_pc (reset_pc)
  ) u_fetch_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .stop       (halted),
    .fetch_req  (fetch_req),
    .fetch_rsp  (fetch_rsp),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_pc    (),
    .inst_taken (inst_taken)
  );

  exec_unit u_exec_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_taken (inst_taken),
    .lsu_start  (lsu_start),
    .lsu_store  (lsu_store),
    .lsu_addr   (lsu_addr),
    .lsu_wdata  (lsu_wdata),
    .lsu_width  (lsu_width),
    .lsu_rdata  (lsu_rdata),
    .lsu_done   (lsu_done),
    .halted     (halted)
  );

  load_store_unit u_load_store_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .lsu_start (lsu_start),
    .lsu_store (lsu_store),
    .lsu_addr  (lsu_addr),
    .lsu_wdata (lsu_wdata),
    .lsu_width (lsu_width),
    .lsu_rdata (lsu_rdata),
    .lsu_done  (lsu_done),
    .data_req  (data_req),
    .data_rsp  (data_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .data_req  (data_req),
    .data_rsp  (data_rsp),
    .axi_out   (axi_out),
    .axi_in    (axi_in)
  );

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;

  // major opcodes handled by the core, anything else is a no-op
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  // straight from funct3 of loads and stores
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_bu = 3'b100,
    mem_hu = 3'b101
  } mem_width_e;

  typedef struct packed {
    opcode_e               opcode;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    word_t                 i_imm;
    word_t                 s_imm;
    word_t                 u_imm;
    alu_op_e               alu_op;
  } decoded_t;

  // requester side of the arbiter
  typedef struct packed {
    logic       valid;
    logic       write;
    word_t      addr;
    word_t      wdata;
    logic [3:0] strb;
  } mem_req_t;

  typedef struct packed {
    logic  done;
    word_t rdata;
  } mem_rsp_t;

  // AXI4-Lite master outputs
  typedef struct packed {
    logic       awvalid;
    word_t      awaddr;
    logic       wvalid;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       bready;
    logic       arvalid;
    word_t      araddr;
    logic       rready;
  } axi_req_t;

  // AXI4-Lite master inputs
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic [1:0] rresp;
  } axi_rsp_t;

endpackage

// File: tb.f
src/rv_pkg.sv
src/fetch_unit.sv
src/exec_unit.sv
src/load_store_unit.sv
src/mem_arbiter.sv
src/rv_core.sv
test/tb_mem.sv
test/tb_core.sv

// File: test/tb_core.sv
`timescale 1ns/10ps

module tb_core import rv_pkg::*; ();

  typedef struct packed {
    word_t      addr;
    word_t      data;
    logic [3:0] strb;
  } store_t;

  logic       clk;
  logic       rst_n;
  axi_req_t   axi_out;
  axi_rsp_t   axi_in;
  logic       halted;
  word_t      prog [$];
  store_t     exp_q [$];
  word_t      ref_regs [32];
  word_t      ref_mem [1024];
  logic [11:0] store_ofs;
  int         errors = 0;
  int         limit = 1000;
  int         aw_seen = 0;
  int         w_seen = 0;
  word_t      next_fetch = '0;
  axi_req_t   prev_out = '0;
  axi_rsp_t   prev_in = '0;
  logic       prev_halted = 1'b0;

  rv_core #(
    .reset_pc (32'h0)
  ) u_rv_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .axi_out (axi_out),
    .axi_in  (axi_in),
    .halted  (halted)
  );

  tb_mem u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .axi_out (axi_out),
    .axi_in  (axi_in)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ************************************************************
  // instruction encoding
  // ************************************************************

  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // ************************************************************
  // reference model, updated as each instruction is emitted
  // ************************************************************

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic set_reg(logic [4:0] rd, word_t v);
    if (rd != 5'd0) begin
      ref_regs[rd] = v;
    end
  endtask

  task automatic rr(logic [2:0] f3, logic alt, logic [4:0] rd, logic [4:0] rs1,
                    logic [4:0] rs2);
    prog.push_back(r_type(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011));
    set_reg(rd, alu_ref(f3, alt, ref_regs[rs1], ref_regs[rs2]));
  endtask

  // srai carries its flag in imm bit 10
  task automatic ri(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    prog.push_back(i_type(imm, rs1, f3, rd, 7'b0010011));
    set_reg(rd, alu_ref(f3, f3 == 3'd5 && imm[10], ref_regs[rs1], sext12(imm)));
  endtask

  task automatic lui(logic [4:0] rd, logic [19:0] u);
    prog.push_back({u, rd, 7'b0110111});
    set_reg(rd, {u, 12'h000});
  endtask

  task automatic store(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    store_t s;
    word_t  addr;
    addr   = ref_regs[rs1] + sext12(imm);
    s.addr = {addr[31:2], 2'b00};
    s.data = ref_regs[rs2] << {addr[1:0], 3'b000};
    case (f3)
      3'd0:    s.strb = 4'b0001 << addr[1:0];
      3'd1:    s.strb = 4'b0011 << addr[1:0];
      default: s.strb = 4'hf;
    endcase
    for (int b = 0; b < 4; b++) begin
      if (s.strb[b]) begin
        ref_mem[addr[11:2]][8*b +: 8] = s.data[8*b +: 8];
      end
    end
    exp_q.push_back(s);
    prog.push_back(s_type(imm, rs2, rs1, f3, 7'b0100011));
  endtask

  task automatic load(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    word_t addr;
    word_t sh;
    addr = ref_regs[rs1] + sext12(imm);
    sh   = ref_mem[addr[11:2]] >> {addr[1:0], 3'b000};
    case (f3)
      3'd0:    set_reg(rd, {{24{sh[7]}}, sh[7:0]});
      3'd4:    set_reg(rd, {24'h000000, sh[7:0]});
      3'd1:    set_reg(rd, {{16{sh[15]}}, sh[15:0]});
      3'd5:    set_reg(rd, {16'h0000, sh[15:0]});
      default: set_reg(rd, ref_mem[addr[11:2]]);
    endcase
    prog.push_back(i_type(imm, rs1, f3, rd, 7'b0000011));
  endtask

  // result stores walk up from x10
  task automatic sw_next(logic [4:0] rs);
    store(3'd2, rs, 5'd10, store_ofs);
    store_ofs = store_ofs + 12'd4;
  endtask

  task automatic put_data(word_t addr, word_t w);
    ref_mem[addr[11:2]] = w;
    u_mem.poke(addr, w);
  endtask

  task automatic build_program();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    store_ofs = '0;
    put_data(32'h400, 32'h80f1_7f05);
    put_data(32'h404, 32'h7f80_01fe);
    ri(3'd0, 5'd10, 5'd0, 12'h500);
    ri(3'd0, 5'd11, 5'd0, 12'h400);
    ri(3'd0, 5'd1, 5'd0, 12'h123);
    sw_next(5'd1);
    ri(3'd0, 5'd2, 5'd0, 12'hff9);
    sw_next(5'd2);
    // reg-reg group
    rr(3'd0, 1'b0, 5'd3, 5'd1, 5'd2);
    sw_next(5'd3);
    rr(3'd0, 1'b1, 5'd4, 5'd2, 5'd1);
    sw_next(5'd4);
    rr(3'd7, 1'b0, 5'd5, 5'd1, 5'd2);
    sw_next(5'd5);
    rr(3'd6, 1'b0, 5'd6, 5'd1, 5'd2);
    sw_next(5'd6);
    rr(3'd4, 1'b0, 5'd7, 5'd1, 5'd2);
    sw_next(5'd7);
    rr(3'd2, 1'b0, 5'd8, 5'd2, 5'd1);
    sw_next(5'd8);
    rr(3'd3, 1'b0, 5'd9, 5'd2, 5'd1);
    sw_next(5'd9);
    ri(3'd0, 5'd13, 5'd0, 12'h005);
    rr(3'd1, 1'b0, 5'd12, 5'd1, 5'd13);
    sw_next(5'd12);
    rr(3'd5, 1'b0, 5'd14, 5'd2, 5'd13);
    sw_next(5'd14);
    rr(3'd5, 1'b1, 5'd15, 5'd2, 5'd13);
    sw_next(5'd15);
    // reg-imm group
    ri(3'd1, 5'd16, 5'd1, 12'h003);
    sw_next(5'd16);
    ri(3'd5, 5'd17, 5'd2, 12'h402);
    sw_next(5'd17);
    ri(3'd2, 5'd20, 5'd2, 12'h000);
    sw_next(5'd20);
    ri(3'd4, 5'd21, 5'd1, 12'hfff);
    sw_next(5'd21);
    ri(3'd7, 5'd22, 5'd1, 12'h0f0);
    sw_next(5'd22);
    ri(3'd6, 5'd23, 5'd1, 12'h800);
    sw_next(5'd23);
    // lui, then writes aimed at x0
    lui(5'd18, 20'habcde);
    sw_next(5'd18);
    ri(3'd0, 5'd0, 5'd1, 12'h055);
    sw_next(5'd0);
    rr(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);
    sw_next(5'd0);
    // byte and half lanes at 0x600
    lui(5'd19, 20'h12345);
    ri(3'd0, 5'd19, 5'd19, 12'h678);
    ri(3'd0, 5'd24, 5'd10, 12'h100);
    for (int o = 0; o < 4; o++) begin
      store(3'd0, 5'd19, 5'd24, 12'(o));
    end
    store(3'd1, 5'd19, 5'd24, 12'h004);
    store(3'd1, 5'd19, 5'd24, 12'h006);
    // loads with extension
    for (int o = 0; o < 4; o++) begin
      load(3'd0, 5'd25, 5'd11, 12'(o));
      sw_next(5'd25);
      load(3'd4, 5'd25, 5'd11, 12'(o));
      sw_next(5'd25);
    end
    for (int o = 0; o < 8; o += 2) begin
      load(3'd1, 5'd25, 5'd11, 12'(o));
      sw_next(5'd25);
      load(3'd5, 5'd25, 5'd11, 12'(o));
      sw_next(5'd25);
    end
    load(3'd2, 5'd25, 5'd11, 12'h004);
    sw_next(5'd25);
    // ebreak
    prog.push_back(i_type(12'h001, 5'd0, 3'd0, 5'd0, 7'b1110011));
    for (int i = 0; i < prog.size(); i++) begin
      u_mem.poke(32'(i) * 32'd4, prog[i]);
    end
  endtask

  // ************************************************************
  // bus checks, between falling and rising edge
  // ************************************************************

  task automatic report_mismatch(string name, word_t got, word_t exp);
    errors++;
    $display("[ERROR] %s got %h expected %h", name, got, exp);
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("problem: %s", what);
  endtask

  task automatic check_bus();
    if (prev_out.awvalid && !prev_in.awready) begin
      assert (axi_out.awvalid) else report_problem("awvalid dropped before awready");
      assert (axi_out.awaddr == prev_out.awaddr)
        else report_mismatch("awaddr", axi_out.awaddr, prev_out.awaddr);
    end
    if (prev_out.wvalid && !prev_in.wready) begin
      assert (axi_out.wvalid) else report_problem("wvalid dropped before wready");
      assert (axi_out.wdata == prev_out.wdata)
        else report_mismatch("wdata", axi_out.wdata, prev_out.wdata);
      assert (axi_out.wstrb == prev_out.wstrb)
        else report_mismatch("wstrb", {28'h0, axi_out.wstrb}, {28'h0, prev_out.wstrb});
    end
    if (prev_out.arvalid && !prev_in.arready) begin
      assert (axi_out.arvalid) else report_problem("arvalid dropped before arready");
      assert (axi_out.araddr == prev_out.araddr)
        else report_mismatch("araddr", axi_out.araddr, prev_out.araddr);
    end
    if (prev_out.rready && !prev_in.rvalid) begin
      assert (axi_out.rready) else report_problem("rready dropped before rvalid");
    end
    if (prev_out.bready && !prev_in.bvalid) begin
      assert (axi_out.bready) else report_problem("bready dropped before bvalid");
    end
    if (prev_halted) begin
      assert (halted) else report_problem("halted fell after it was raised");
    end
    // address and data beats of a store may be accepted in different cycles
    if (axi_out.awvalid && axi_in.awready) begin
      assert (!halted) else report_problem("write address seen after halt");
      assert (aw_seen < exp_q.size())
        else report_problem("write address seen with no expected store left");
      if (aw_seen < exp_q.size()) begin
        assert (axi_out.awaddr == exp_q[aw_seen].addr)
          else report_mismatch("awaddr", axi_out.awaddr, exp_q[aw_seen].addr);
      end
      aw_seen++;
    end
    if (axi_out.wvalid && axi_in.wready) begin
      assert (w_seen < exp_q.size())
        else report_problem("write data seen with no expected store left");
      if (w_seen < exp_q.size()) begin
        assert (axi_out.wdata == exp_q[w_seen].data)
          else report_mismatch("wdata", axi_out.wdata, exp_q[w_seen].data);
        assert (axi_out.wstrb == exp_q[w_seen].strb)
          else report_mismatch("wstrb", {28'h0, axi_out.wstrb}, {28'h0, exp_q[w_seen].strb});
      end
      w_seen++;
    end
    // instruction space sits below the data area
    if (axi_out.arvalid && axi_in.arready && axi_out.araddr < 32'h400) begin
      assert (axi_out.araddr == next_fetch)
        else report_mismatch("araddr", axi_out.araddr, next_fetch);
      next_fetch = axi_out.araddr + 32'd4;
    end
  endtask

  always begin
    @(negedge clk);
    #1;
    if (rst_n) begin
      check_bus();
    end
    prev_out    = axi_out;
    prev_in     = axi_in;
    prev_halted = halted;
  end

  initial begin
    @(posedge rst_n);
    repeat (limit) @(posedge clk);
    $display("timeout: core did not halt within %0d cycles", limit);
    $display("errors: %0d", errors + 1);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    @(negedge clk);
    build_program();
    limit = 40 * prog.size() + 200;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (!halted) begin
      @(negedge clk);
    end
    // quiet period, no more writes may follow
    repeat (20) @(negedge clk);
    assert (aw_seen >= exp_q.size())
      else report_problem($sformatf("halted with %0d expected stores not seen",
                                    exp_q.size() - aw_seen));
    assert (w_seen >= exp_q.size())
      else report_problem($sformatf("halted with %0d expected write data beats not seen",
                                    exp_q.size() - w_seen));
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: test/tb_mem.sv
`timescale 1ns/10ps

module tb_mem import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  axi_req_t axi_out,
  output axi_rsp_t axi_in
);

  word_t      mem [1024];
  axi_rsp_t   rsp_q = '0;
  int         seed;
  int         ar_dly;
  int         r_dly;
  int         aw_dly;
  int         w_dly;
  int         b_dly;
  logic       r_pend;
  logic       aw_got;
  logic       w_got;
  logic       ar_hs;
  logic       r_hs;
  logic       aw_hs;
  logic       w_hs;
  logic       b_hs;
  word_t      ar_addr_l;
  word_t      aw_addr_l;
  word_t      w_data_l;
  logic [3:0] w_strb_l;

  assign axi_in = rsp_q;

  function automatic int pick_delay();
    return int'($unsigned($random(seed)) % 4);
  endfunction

  task automatic poke(word_t addr, word_t data);
    mem[addr[11:2]] = data;
  endtask

  // background pattern, every word differs
  initial begin
    seed = 62258;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (32'(i) * 32'h0101_0101) ^ 32'h5a00_00a5;
    end
  end

  // ************************************************************
  // slave channels, driven on the falling edge
  // ************************************************************

  // the hs flags hold what the next rising edge will complete
  always @(negedge clk) begin : drive
    axi_rsp_t nxt;
    nxt         = rsp_q;
    nxt.arready = 1'b0;
    nxt.awready = 1'b0;
    nxt.wready  = 1'b0;
    if (!rst_n) begin
      nxt    = '0;
      r_pend = 1'b0;
      aw_got = 1'b0;
      w_got  = 1'b0;
      ar_dly = 0;
      aw_dly = 0;
      w_dly  = 0;
      b_dly  = 0;
    end else begin
      // read side
      if (r_hs) begin
        nxt.rvalid = 1'b0;
      end
      if (ar_hs) begin
        r_pend = 1'b1;
        r_dly  = pick_delay();
      end else if (r_pend) begin
        if (r_dly == 0) begin
          nxt.rvalid = 1'b1;
          nxt.rdata  = mem[ar_addr_l[11:2]];
          r_pend     = 1'b0;
        end else begin
          r_dly--;
        end
      end else if (axi_out.arvalid && !nxt.rvalid) begin
        if (ar_dly == 0) begin
          nxt.arready = 1'b1;
          ar_addr_l   = axi_out.araddr;
          ar_dly      = pick_delay();
        end else begin
          ar_dly--;
        end
      end
      // write side, aw and w accepted independently
      if (aw_hs) begin
        aw_got = 1'b1;
      end
      if (w_hs) begin
        w_got = 1'b1;
      end
      if (b_hs) begin
        nxt.bvalid = 1'b0;
      end
      if (axi_out.awvalid && !aw_got) begin
        if (aw_dly == 0) begin
          nxt.awready = 1'b1;
          aw_addr_l   = axi_out.awaddr;
          aw_dly      = pick_delay();
        end else begin
          aw_dly--;
        end
      end
      if (axi_out.wvalid && !w_got) begin
        if (w_dly == 0) begin
          nxt.wready = 1'b1;
          w_data_l   = axi_out.wdata;
          w_strb_l   = axi_out.wstrb;
          w_dly      = pick_delay();
        end else begin
          w_dly--;
        end
      end
      if (aw_got && w_got) begin
        if (b_dly == 0) begin
          for (int b = 0; b < 4; b++) begin
            if (w_strb_l[b]) begin
              mem[aw_addr_l[11:2]][8*b +: 8] = w_data_l[8*b +: 8];
            end
          end
          nxt.bvalid = 1'b1;
          aw_got     = 1'b0;
          w_got      = 1'b0;
          b_dly      = pick_delay();
        end else begin
          b_dly--;
        end
      end
    end
    ar_hs = nxt.arready;
    aw_hs = nxt.awready;
    w_hs  = nxt.wready;
    r_hs  = nxt.rvalid && axi_out.rready;
    b_hs  = nxt.bvalid && axi_out.bready;
    rsp_q <= nxt;
  end

endmodule
